//--- hdl/mem_arb_settings.svh
`default_nettype none

`ifndef MEM_ARB_SETTINGS_SVH
`define MEM_ARB_SETTINGS_SVH

////////////////////////////////////////
// Memory port widths
////////////////////////////////////////

// Transaction tag width, tag zero means no transaction
`define MEM_TAG_BITS 4

// Byte address
`define ADDR_BITS 32

// One memory block per transfer
`define BLOCK_BITS 64

////////////////////////////////////////
// Arbitration
////////////////////////////////////////

// Denied cycles before instruction fetch turns urgent
`define STARVE_LIMIT 6

`endif

`default_nettype wire

//--- hdl/mem_arb_pkg.sv
`include "mem_arb_settings.svh"
`default_nettype none

package mem_arb_pkg;

    // Command driven on the memory port
    typedef enum logic [1:0] {
        MEM_NONE  = 2'h0,
        MEM_LOAD  = 2'h1,
        MEM_STORE = 2'h2
    } mem_command_t;

    // Requester that owns a command
    typedef enum logic [1:0] {
        SRC_WB    = 2'h0,
        SRC_DLOAD = 2'h1,
        SRC_ILOAD = 2'h2
    } mem_src_t;

    typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;
    typedef logic [`ADDR_BITS-1:0]    addr_t;
    typedef logic [`BLOCK_BITS-1:0]   block_t;

    // Dirty writeback, address plus block
    typedef struct packed {
        addr_t  addr;
        block_t data;
    } wb_req_t;

    // Loads carry an address only
    typedef struct packed {
        addr_t addr;
    } load_req_t;

endpackage

`default_nettype wire

//--- hdl/issue_if.sv
`default_nettype none

// Issue record of an accepted load
interface issue_if;
    import mem_arb_pkg::*;

    // One pulse per load the memory accepted
    logic     issue_fire;
    // Who asked for it
    mem_src_t issue_src;
    // Tag the memory handed out
    mem_tag_t issue_tag;

    // Arbiter side
    modport ctrl (
        output issue_fire,
        output issue_src,
        output issue_tag
    );

    // Tag table side
    modport tbl (
        input issue_fire,
        input issue_src,
        input issue_tag
    );
endinterface

`default_nettype wire

//--- hdl/req_slot.sv
`default_nettype none

module req_slot #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     arst_n,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     in_ready,
    input  logic     take,
    output logic     full,
    output payload_t payload
);

    logic load_en;

    // Room only while empty
    assign in_ready = !full;
    assign load_en  = in_valid && in_ready;

    // Occupancy flag
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else if (load_en) begin
            full <= 1'b1;
        end else if (take) begin
            // Memory accepted the held command
            full <= 1'b0;
        end
    end

    // Held request, stable until taken
    always_ff @(posedge clock) begin
        if (load_en) begin
            payload <= in_payload;
        end
    end

endmodule

`default_nettype wire

//--- hdl/starve_timer.sv
`include "mem_arb_settings.svh"
`default_nettype none

module starve_timer (
    input  logic clock,
    input  logic arst_n,
    input  logic waiting,
    input  logic served,
    output logic expired
);

    // Wide enough to hold the limit itself
    localparam int COUNT_BITS = $clog2(`STARVE_LIMIT + 1);
    localparam logic [COUNT_BITS-1:0] LIMIT = COUNT_BITS'(`STARVE_LIMIT);

    logic [COUNT_BITS-1:0] count;

    // Denied cycles of the instruction slot
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (served) begin
            count <= '0;
        end else if (waiting && (count != LIMIT)) begin
            // Saturates at the limit
            count <= count + 1'b1;
        end
    end

    // Stays high until the slot is served
    assign expired = (count == LIMIT);

endmodule

`default_nettype wire

//--- hdl/arb_fsm.sv
`default_nettype none

module arb_fsm (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      wb_full,
    input  logic                      dload_full,
    input  logic                      iload_full,
    input  mem_arb_pkg::wb_req_t      wb_payload,
    input  mem_arb_pkg::load_req_t    dload_payload,
    input  mem_arb_pkg::load_req_t    iload_payload,
    input  logic                      starve_expired,
    input  mem_arb_pkg::mem_tag_t     mem_transaction_tag,
    output logic                      wb_take,
    output logic                      dload_take,
    output logic                      iload_take,
    output mem_arb_pkg::mem_command_t mem_command,
    output mem_arb_pkg::addr_t        mem_addr,
    output mem_arb_pkg::block_t       mem_data,
    issue_if.ctrl                     issue
);
    import mem_arb_pkg::*;

    typedef enum logic {
        NORMAL = 1'b0,
        URGENT = 1'b1
    } state_t;

    state_t   state;
    state_t   state_next;
    mem_src_t win_src;
    logic     win_valid;
    logic     accept;

    ////////////////////////////////////////
    // Winner selection
    ////////////////////////////////////////

    always_comb begin
        win_valid = 1'b1;
        win_src   = SRC_WB;
        // Urgent fetch jumps the queue
        if ((state == URGENT) && iload_full) begin
            win_src = SRC_ILOAD;
        end else if (wb_full) begin
            win_src = SRC_WB;
        end else if (dload_full) begin
            win_src = SRC_DLOAD;
        end else if (iload_full) begin
            win_src = SRC_ILOAD;
        end else begin
            win_valid = 1'b0;
        end
    end

    // Memory command from the winner
    always_comb begin
        mem_command = MEM_NONE;
        mem_addr    = '0;
        mem_data    = '0;
        if (win_valid) begin
            case (win_src)
                SRC_WB: begin
                    mem_command = MEM_STORE;
                    mem_addr    = wb_payload.addr;
                    mem_data    = wb_payload.data;
                end
                SRC_DLOAD: begin
                    mem_command = MEM_LOAD;
                    mem_addr    = dload_payload.addr;
                end
                default: begin
                    mem_command = MEM_LOAD;
                    mem_addr    = iload_payload.addr;
                end
            endcase
        end
    end

    // Nonzero tag means the memory took it, stores included
    assign accept     = win_valid && (mem_transaction_tag != '0);
    assign wb_take    = accept && (win_src == SRC_WB);
    assign dload_take = accept && (win_src == SRC_DLOAD);
    assign iload_take = accept && (win_src == SRC_ILOAD);

    // Loads only go to the tag table
    assign issue.issue_fire = accept && (win_src != SRC_WB);
    assign issue.issue_src  = win_src;
    assign issue.issue_tag  = mem_transaction_tag;

    ////////////////////////////////////////
    // Urgent fetch FSM
    ////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            NORMAL: begin
                // A fetch served this cycle needs no boost
                if (starve_expired && !iload_take) begin
                    state_next = URGENT;
                end
            end
            default: begin
                if (iload_take) begin
                    state_next = NORMAL;
                end
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= NORMAL;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/tag_table.sv
`default_nettype none

module tag_table (
    input  logic                  clock,
    input  logic                  arst_n,
    input  mem_arb_pkg::mem_tag_t mem_data_tag,
    input  mem_arb_pkg::block_t   mem_rdata,
    issue_if.tbl                  issue,
    output logic                  dload_resp_valid,
    output logic                  iload_resp_valid,
    output mem_arb_pkg::block_t   dload_resp_data,
    output mem_arb_pkg::block_t   iload_resp_data
);
    import mem_arb_pkg::*;

    // One entry per tag value, entry zero never filled
    localparam int TAG_COUNT = 2 ** $bits(mem_tag_t);

    logic [TAG_COUNT-1:0] entry_valid;
    mem_src_t             entry_src [TAG_COUNT];
    logic                 resp_hit;
    mem_src_t             resp_src;
    logic                 hit_dload;
    logic                 hit_iload;

    // Lookup of the returning tag
    assign resp_hit  = (mem_data_tag != '0) && entry_valid[mem_data_tag];
    assign resp_src  = entry_src[mem_data_tag];
    assign hit_dload = resp_hit && (resp_src == SRC_DLOAD);
    assign hit_iload = resp_hit && (resp_src == SRC_ILOAD);

    ////////////////////////////////////////
    // Outstanding loads
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            entry_valid <= '0;
        end else begin
            if (resp_hit) begin
                entry_valid[mem_data_tag] <= 1'b0;
            end
            // Tag reused on the same edge stays live
            if (issue.issue_fire) begin
                entry_valid[issue.issue_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (issue.issue_fire) begin
            entry_src[issue.issue_tag] <= issue.issue_src;
        end
    end

    ////////////////////////////////////////
    // Response registers
    ////////////////////////////////////////

    // Single cycle pulse, one cycle after the tag
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            dload_resp_valid <= 1'b0;
            iload_resp_valid <= 1'b0;
        end else begin
            dload_resp_valid <= hit_dload;
            iload_resp_valid <= hit_iload;
        end
    end

    always_ff @(posedge clock) begin
        if (hit_dload) begin
            dload_resp_data <= mem_rdata;
        end
        if (hit_iload) begin
            iload_resp_data <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- hdl/mem_arbiter.sv
`default_nettype none

module mem_arbiter (
    input  logic                      clock,
    input  logic                      arst_n,
    // Dirty writeback requester
    input  logic                      wb_valid,
    output logic                      wb_ready,
    input  mem_arb_pkg::addr_t        wb_addr,
    input  mem_arb_pkg::block_t       wb_data,
    // Data load requester
    input  logic                      dload_valid,
    output logic                      dload_ready,
    input  mem_arb_pkg::addr_t        dload_addr,
    // Instruction load requester
    input  logic                      iload_valid,
    output logic                      iload_ready,
    input  mem_arb_pkg::addr_t        iload_addr,
    // Load responses
    output logic                      dload_resp_valid,
    output mem_arb_pkg::block_t       dload_resp_data,
    output logic                      iload_resp_valid,
    output mem_arb_pkg::block_t       iload_resp_data,
    // Memory port
    output mem_arb_pkg::mem_command_t mem_command,
    output mem_arb_pkg::addr_t        mem_addr,
    output mem_arb_pkg::block_t       mem_data,
    input  mem_arb_pkg::mem_tag_t     mem_transaction_tag,
    input  mem_arb_pkg::mem_tag_t     mem_data_tag,
    input  mem_arb_pkg::block_t       mem_rdata
);
    import mem_arb_pkg::*;

    wb_req_t   wb_in;
    wb_req_t   wb_payload;
    load_req_t dload_in;
    load_req_t dload_payload;
    load_req_t iload_in;
    load_req_t iload_payload;
    logic      wb_full;
    logic      dload_full;
    logic      iload_full;
    logic      wb_take;
    logic      dload_take;
    logic      iload_take;
    logic      starve_expired;

    issue_if issue_bus ();

    // Pack requester fields into slot payloads
    assign wb_in.addr    = wb_addr;
    assign wb_in.data    = wb_data;
    assign dload_in.addr = dload_addr;
    assign iload_in.addr = iload_addr;

    ////////////////////////////////////////
    // Request slots
    ////////////////////////////////////////

    req_slot #(.payload_t(wb_req_t)) wb_slot (
        .clock(clock), .arst_n(arst_n),
        .in_valid(wb_valid), .in_payload(wb_in), .in_ready(wb_ready),
        .take(wb_take), .full(wb_full), .payload(wb_payload)
    );

    req_slot #(.payload_t(load_req_t)) dload_slot (
        .clock(clock), .arst_n(arst_n),
        .in_valid(dload_valid), .in_payload(dload_in), .in_ready(dload_ready),
        .take(dload_take), .full(dload_full), .payload(dload_payload)
    );

    req_slot #(.payload_t(load_req_t)) iload_slot (
        .clock(clock), .arst_n(arst_n),
        .in_valid(iload_valid), .in_payload(iload_in), .in_ready(iload_ready),
        .take(iload_take), .full(iload_full), .payload(iload_payload)
    );

    // Fetch waits while its slot is full and untaken
    starve_timer fetch_timer (
        .clock(clock), .arst_n(arst_n),
        .waiting(iload_full), .served(iload_take), .expired(starve_expired)
    );

    ////////////////////////////////////////
    // Arbitration and response routing
    ////////////////////////////////////////

    arb_fsm arb (
        .clock(clock), .arst_n(arst_n),
        .wb_full(wb_full), .dload_full(dload_full), .iload_full(iload_full),
        .wb_payload(wb_payload), .dload_payload(dload_payload),
        .iload_payload(iload_payload), .starve_expired(starve_expired),
        .mem_transaction_tag(mem_transaction_tag),
        .wb_take(wb_take), .dload_take(dload_take), .iload_take(iload_take),
        .mem_command(mem_command), .mem_addr(mem_addr), .mem_data(mem_data),
        .issue(issue_bus)
    );

    tag_table tags (
        .clock(clock), .arst_n(arst_n),
        .mem_data_tag(mem_data_tag), .mem_rdata(mem_rdata), .issue(issue_bus),
        .dload_resp_valid(dload_resp_valid), .iload_resp_valid(iload_resp_valid),
        .dload_resp_data(dload_resp_data), .iload_resp_data(iload_resp_data)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clock,
    output logic arst_n
);

    // Free running clock, first rising edge half a period in
    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Reset held low for the first cycles, released on a falling edge
    initial begin
        arst_n = 1'b0;
        #(PERIOD * RESET_CYCLES);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/mem_arbiter_assert.sv
`default_nettype none

module mem_arbiter_assert (
    input logic                      clock,
    input logic                      arst_n,
    input logic                      wb_ready,
    input logic                      dload_ready,
    input logic                      iload_ready,
    input logic                      wb_full,
    input logic                      dload_full,
    input logic                      iload_full,
    input logic                      wb_take,
    input logic                      dload_take,
    input logic                      iload_take,
    input mem_arb_pkg::mem_command_t mem_command,
    input mem_arb_pkg::mem_tag_t     mem_data_tag,
    input logic                      dload_resp_valid,
    input logic                      iload_resp_valid
);
    import mem_arb_pkg::*;

    // Failed assertions so far, polled by the testbench
    int unsigned error_count = 0;

    logic [2:0] held;
    logic [2:0] ready;

    // Slots holding a command the memory has not accepted yet
    assign held  = {wb_full && !wb_take, dload_full && !dload_take,
                    iload_full && !iload_take};
    assign ready = {wb_ready, dload_ready, iload_ready};

    ////////////////////////////////////////
    // Request side
    ////////////////////////////////////////

    // A held command keeps its slot closed on the next edge
    held_not_ready: assert property (@(posedge clock) disable iff (!arst_n)
        (held != '0) |=> ((ready & $past(held)) == '0))
        else begin
            error_count = error_count + 1;
            $error("Slot ready while its command is still unaccepted");
        end

    // Empty slots, idle port
    idle_port: assert property (@(posedge clock) disable iff (!arst_n)
        !(wb_full || dload_full || iload_full) |-> (mem_command == MEM_NONE))
        else begin
            error_count = error_count + 1;
            $error("Memory command driven with all slots empty");
        end

    ////////////////////////////////////////
    // Response side
    ////////////////////////////////////////

    one_response: assert property (@(posedge clock) disable iff (!arst_n)
        !(dload_resp_valid && iload_resp_valid))
        else begin
            error_count = error_count + 1;
            $error("Both load responses valid in one cycle");
        end

    // Every response follows a returned tag
    tag_before_resp: assert property (@(posedge clock) disable iff (!arst_n)
        (dload_resp_valid || iload_resp_valid) |-> ($past(mem_data_tag) != '0))
        else begin
            error_count = error_count + 1;
            $error("Load response without a data tag one cycle earlier");
        end

endmodule

bind mem_arbiter mem_arbiter_assert arb_checks (
    .clock(clock), .arst_n(arst_n),
    .wb_ready(wb_ready), .dload_ready(dload_ready), .iload_ready(iload_ready),
    .wb_full(wb_full), .dload_full(dload_full), .iload_full(iload_full),
    .wb_take(wb_take), .dload_take(dload_take), .iload_take(iload_take),
    .mem_command(mem_command), .mem_data_tag(mem_data_tag),
    .dload_resp_valid(dload_resp_valid), .iload_resp_valid(iload_resp_valid)
);

`default_nettype wire

//--- testbench/tb_mem_arbiter.sv
`default_nettype none

module tb_mem_arbiter;
    import mem_arb_pkg::*;

    localparam int TAG_COUNT = 2 ** $bits(mem_tag_t);

    // Request addresses, one set per scenario
    localparam addr_t A_WB      = 32'h0000_1000;
    localparam addr_t A_DL      = 32'h0000_2000;
    localparam addr_t A_IL      = 32'h0000_3000;
    localparam addr_t A_DL_HOLD = 32'h0000_2040;
    localparam addr_t A_WB_S    = 32'h0000_1100;
    localparam addr_t A_DL_S    = 32'h0000_2100;
    localparam addr_t A_IL_S    = 32'h0000_3100;

    // Inputs of one cycle and the outputs seen during it
    typedef struct {
        logic [2:0]   req;
        addr_t        wb_addr;
        addr_t        dload_addr;
        addr_t        iload_addr;
        mem_tag_t     trans_tag;
        mem_tag_t     data_tag;
        logic [2:0]   ready;
        mem_command_t cmd;
        addr_t        addr;
        mem_src_t     src;
    } step_t;

    logic         clock;
    logic         arst_n;
    logic         wb_valid;
    logic         wb_ready;
    addr_t        wb_addr;
    block_t       wb_data;
    logic         dload_valid;
    logic         dload_ready;
    addr_t        dload_addr;
    logic         iload_valid;
    logic         iload_ready;
    addr_t        iload_addr;
    logic         dload_resp_valid;
    block_t       dload_resp_data;
    logic         iload_resp_valid;
    block_t       iload_resp_data;
    mem_command_t mem_command;
    addr_t        mem_addr;
    block_t       mem_data;
    mem_tag_t     mem_transaction_tag;
    mem_tag_t     mem_data_tag;
    block_t       mem_rdata;

    step_t        steps[$];
    int           cycle_count = 0;
    int           cycle_limit = 0;
    // Memory model, owner of each outstanding tag
    logic         tag_live [TAG_COUNT];
    mem_src_t     tag_owner [TAG_COUNT];

    tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(4)) clock_gen (
        .clock(clock), .arst_n(arst_n)
    );

    mem_arbiter dut (
        .clock(clock), .arst_n(arst_n),
        .wb_valid(wb_valid), .wb_ready(wb_ready), .wb_addr(wb_addr), .wb_data(wb_data),
        .dload_valid(dload_valid), .dload_ready(dload_ready), .dload_addr(dload_addr),
        .iload_valid(iload_valid), .iload_ready(iload_ready), .iload_addr(iload_addr),
        .dload_resp_valid(dload_resp_valid), .dload_resp_data(dload_resp_data),
        .iload_resp_valid(iload_resp_valid), .iload_resp_data(iload_resp_data),
        .mem_command(mem_command), .mem_addr(mem_addr), .mem_data(mem_data),
        .mem_transaction_tag(mem_transaction_tag), .mem_data_tag(mem_data_tag),
        .mem_rdata(mem_rdata)
    );

    // Store payload tied to its address
    function automatic block_t writeback_block(input addr_t addr);
        return {~addr, addr};
    endfunction

    task automatic add_step(input logic [2:0] req, input addr_t wa, input addr_t da,
                            input addr_t ia, input mem_tag_t tt, input mem_tag_t dt,
                            input logic [2:0] rdy, input mem_command_t cmd,
                            input addr_t ea, input mem_src_t src);
        step_t st;
        st.req        = req;
        st.wb_addr    = wa;
        st.dload_addr = da;
        st.iload_addr = ia;
        st.trans_tag  = tt;
        st.data_tag   = dt;
        st.ready      = rdy;
        st.cmd        = cmd;
        st.addr       = ea;
        st.src        = src;
        steps.push_back(st);
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first failure");
    endtask

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_cmd(input string name, input mem_command_t got,
                             input mem_command_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at time %0t: %s is %s, expected %s",
                               $time, name, got.name(), exp.name()));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_block(input string name, input block_t got, input block_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at time %0t: %s is %b, expected %b",
                               $time, name, got, exp));
        end
    endtask

    task automatic drive_step(input step_t st);
        wb_valid            = st.req[2];
        wb_addr             = st.wb_addr;
        wb_data             = writeback_block(st.wb_addr);
        dload_valid         = st.req[1];
        dload_addr          = st.dload_addr;
        iload_valid         = st.req[0];
        iload_addr          = st.iload_addr;
        mem_transaction_tag = st.trans_tag;
        mem_data_tag        = st.data_tag;
        // Returned block, used only under a nonzero data tag
        mem_rdata           = {$urandom, $urandom};
    endtask

    ////////////////////////////////////////
    // Step table
    ////////////////////////////////////////

    task automatic build_table();
        // Idle after reset
        add_step(3'b000, '0, '0, '0, 4'd0, 4'd0, 3'b111, MEM_NONE, '0, SRC_WB);
        // All three at once, priority order store, data, fetch
        add_step(3'b111, A_WB, A_DL, A_IL, 4'd0, 4'd0, 3'b111, MEM_NONE, '0, SRC_WB);
        add_step(3'b000, '0, '0, '0, 4'd1, 4'd0, 3'b000, MEM_STORE, A_WB, SRC_WB);
        add_step(3'b000, '0, '0, '0, 4'd2, 4'd0, 3'b100, MEM_LOAD, A_DL, SRC_DLOAD);
        add_step(3'b000, '0, '0, '0, 4'd3, 4'd0, 3'b110, MEM_LOAD, A_IL, SRC_ILOAD);
        // Zero tag holds the load, tags 2 and 3 come back meanwhile
        add_step(3'b010, '0, A_DL_HOLD, '0, 4'd0, 4'd0, 3'b111, MEM_NONE, '0, SRC_WB);
        add_step(3'b000, '0, '0, '0, 4'd0, 4'd2, 3'b101, MEM_LOAD, A_DL_HOLD, SRC_DLOAD);
        add_step(3'b000, '0, '0, '0, 4'd0, 4'd3, 3'b101, MEM_LOAD, A_DL_HOLD, SRC_DLOAD);
        // Tag 9 has no owner
        add_step(3'b000, '0, '0, '0, 4'd4, 4'd9, 3'b101, MEM_LOAD, A_DL_HOLD, SRC_DLOAD);
        // Tag 1 went to a store
        add_step(3'b000, '0, '0, '0, 4'd0, 4'd1, 3'b111, MEM_NONE, '0, SRC_WB);
        add_step(3'b000, '0, '0, '0, 4'd0, 4'd4, 3'b111, MEM_NONE, '0, SRC_WB);
        // Stores and data loads alternate while the fetch waits
        add_step(3'b111, A_WB_S, A_DL_S, A_IL_S, 4'd0, 4'd0, 3'b111, MEM_NONE, '0, SRC_WB);
        add_step(3'b110, A_WB_S, A_DL_S, '0, 4'd5, 4'd0, 3'b000, MEM_STORE, A_WB_S, SRC_WB);
        add_step(3'b110, A_WB_S, A_DL_S, '0, 4'd6, 4'd0, 3'b100, MEM_LOAD, A_DL_S, SRC_DLOAD);
        add_step(3'b110, A_WB_S, A_DL_S, '0, 4'd7, 4'd0, 3'b010, MEM_STORE, A_WB_S, SRC_WB);
        add_step(3'b110, A_WB_S, A_DL_S, '0, 4'd8, 4'd0, 3'b100, MEM_LOAD, A_DL_S, SRC_DLOAD);
        add_step(3'b110, A_WB_S, A_DL_S, '0, 4'd9, 4'd0, 3'b010, MEM_STORE, A_WB_S, SRC_WB);
        add_step(3'b110, A_WB_S, A_DL_S, '0, 4'd10, 4'd0, 3'b100, MEM_LOAD, A_DL_S, SRC_DLOAD);
        // Limit reached here, one more denied cycle
        add_step(3'b010, '0, A_DL_S, '0, 4'd11, 4'd0, 3'b010, MEM_STORE, A_WB_S, SRC_WB);
        // Urgent fetch, then data loads again
        add_step(3'b000, '0, '0, '0, 4'd12, 4'd0, 3'b100, MEM_LOAD, A_IL_S, SRC_ILOAD);
        add_step(3'b000, '0, '0, '0, 4'd13, 4'd0, 3'b101, MEM_LOAD, A_DL_S, SRC_DLOAD);
        add_step(3'b000, '0, '0, '0, 4'd0, 4'd12, 3'b111, MEM_NONE, '0, SRC_WB);
        add_step(3'b000, '0, '0, '0, 4'd0, 4'd10, 3'b111, MEM_NONE, '0, SRC_WB);
        add_step(3'b000, '0, '0, '0, 4'd0, 4'd0, 3'b111, MEM_NONE, '0, SRC_WB);
    endtask

    // Run limit from the table length
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            fail_run($sformatf("Timeout after %0d cycles, the step table did not finish",
                               cycle_count));
        end
    end

    initial begin
        step_t       st;
        int          idx;
        int unsigned seed;
        logic        exp_dload_valid;
        logic        exp_iload_valid;
        block_t      exp_dload_data;
        block_t      exp_iload_data;

        seed                = $urandom(56);
        wb_valid            = 1'b0;
        wb_addr             = '0;
        wb_data             = '0;
        dload_valid         = 1'b0;
        dload_addr          = '0;
        iload_valid         = 1'b0;
        iload_addr          = '0;
        mem_transaction_tag = '0;
        mem_data_tag        = '0;
        mem_rdata           = '0;
        exp_dload_valid     = 1'b0;
        exp_iload_valid     = 1'b0;
        exp_dload_data      = '0;
        exp_iload_data      = '0;
        for (idx = 0; idx < TAG_COUNT; idx++) begin
            tag_live[idx]  = 1'b0;
            tag_owner[idx] = SRC_WB;
        end
        build_table();
        cycle_limit = steps.size() * 4 + 20;

        wait (arst_n === 1'b1);
        for (idx = 0; idx < steps.size(); idx++) begin
            st = steps[idx];
            @(posedge clock);
            #1;
            drive_step(st);
            // Mid cycle, outputs settled
            @(negedge clock);
            check_bit("wb_ready", wb_ready, st.ready[2]);
            check_bit("dload_ready", dload_ready, st.ready[1]);
            check_bit("iload_ready", iload_ready, st.ready[0]);
            check_cmd("mem_command", mem_command, st.cmd);
            check_addr("mem_addr", mem_addr, st.addr);
            check_block("mem_data", mem_data,
                        (st.cmd == MEM_STORE) ? writeback_block(st.addr) : '0);
            check_bit("dload_resp_valid", dload_resp_valid, exp_dload_valid);
            check_bit("iload_resp_valid", iload_resp_valid, exp_iload_valid);
            if (exp_dload_valid) begin
                check_block("dload_resp_data", dload_resp_data, exp_dload_data);
            end
            if (exp_iload_valid) begin
                check_block("iload_resp_data", iload_resp_data, exp_iload_data);
            end
            if (dut.arb_checks.error_count != 0) begin
                fail_run("A bound assertion on the arbiter failed");
            end

            // Returning tag first, then this cycle's accepted load
            exp_dload_valid = 1'b0;
            exp_iload_valid = 1'b0;
            if ((st.data_tag != '0) && tag_live[st.data_tag]) begin
                tag_live[st.data_tag] = 1'b0;
                if (tag_owner[st.data_tag] == SRC_DLOAD) begin
                    exp_dload_valid = 1'b1;
                    exp_dload_data  = mem_rdata;
                end else begin
                    exp_iload_valid = 1'b1;
                    exp_iload_data  = mem_rdata;
                end
            end
            if ((st.trans_tag != '0) && (st.cmd == MEM_LOAD)) begin
                tag_live[st.trans_tag]  = 1'b1;
                tag_owner[st.trans_tag] = st.src;
            end
        end

        if (dut.arb_checks.error_count != 0) begin
            fail_run("A bound assertion on the arbiter failed");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+hdl
hdl/mem_arb_pkg.sv
hdl/issue_if.sv
hdl/req_slot.sv
hdl/starve_timer.sv
hdl/arb_fsm.sv
hdl/tag_table.sv
hdl/mem_arbiter.sv
testbench/tb_clock_gen.sv
testbench/mem_arbiter_assert.sv
testbench/tb_mem_arbiter.sv
